/* source/mem_pkg.sv */
package mem_pkg;

    localparam int WORD_W         = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int LINE_ADDR_W    = 14;    // word address minus offset

    localparam int MEM_LATENCY = 4;        // accept to completion
    localparam int MEM_LINES   = 16384;
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [LINE_W-1:0]      line_t;    // word 0 in the top bits
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [LAT_CNT_W-1:0]   lat_cnt_t;

    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_t      wdata;
    } mem_req_t;

    // read data only, writes finish on accept
    typedef struct packed {
        line_t rdata;
    } mem_resp_t;

endpackage

/* source/cache_pkg.sv */
package cache_pkg;

    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 2;
    localparam int TAG_W    = 13;
    localparam int COUNT_W  = 16;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    typedef struct packed {
        logic [TAG_W-1:0]                            tag;
        logic [$clog2(NUM_SETS)-1:0]                 index;
        logic [$clog2(mem_pkg::WORDS_PER_LINE)-1:0]  offset;
    } cache_addr_t;

    // same word seen raw or split into fields
    typedef union packed {
        mem_pkg::word_t raw;
        cache_addr_t    f;
    } cache_addr_u;

    typedef struct packed {
        logic           write;
        cache_addr_u    addr;
        mem_pkg::word_t wdata;
    } cache_req_t;

    typedef struct packed {
        mem_pkg::word_t rdata;    // zero for writes
        logic           hit;
    } cache_resp_t;

endpackage

/* source/cache_tag_store.sv */
`timescale 1ns/10ps

module cache_tag_store (
    input  logic                  clk,
    input  logic                  reset_n,
    input  cache_pkg::cache_addr_u lookup_addr,
    input  logic                  touch,
    input  cache_pkg::way_t       touch_way,
    input  logic                  install,
    input  cache_pkg::way_t       install_way,
    input  logic                  set_dirty,
    output logic                  hit,
    output cache_pkg::way_t       hit_way,
    output cache_pkg::way_t       victim_way,
    output logic                  victim_dirty,
    output mem_pkg::line_addr_t   victim_line_addr
);

    logic [cache_pkg::TAG_W-1:0]    tag_q   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic [cache_pkg::NUM_WAYS-1:0] valid_q [cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_WAYS-1:0] dirty_q [cache_pkg::NUM_SETS];
    cache_pkg::way_t                lru_q   [cache_pkg::NUM_SETS];    // least recently used

    logic                           idx;
    logic [cache_pkg::NUM_WAYS-1:0] way_match;

    assign idx = lookup_addr.f.index;

    // both ways compared in parallel
    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            way_match[w] = valid_q[idx][w] && (tag_q[idx][w] == lookup_addr.f.tag);
        end
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (way_match[w]) begin
                hit     = 1'b1;
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    // invalid way wins, lowest first, else lru
    always_comb begin
        victim_way = lru_q[idx];
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[idx][w]) begin
                victim_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign victim_dirty     = valid_q[idx][victim_way] && dirty_q[idx][victim_way];
    assign victim_line_addr = {tag_q[idx][victim_way], idx};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= '0;
            end
        end else if (install) begin
            valid_q[idx][install_way] <= 1'b1;
            dirty_q[idx][install_way] <= 1'b0;    // fresh from memory
            lru_q[idx]                <= ~install_way;
        end else if (touch) begin
            lru_q[idx] <= ~touch_way;
            if (set_dirty) begin
                dirty_q[idx][touch_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tag_q[idx][install_way] <= lookup_addr.f.tag;
        end
    end

endmodule

/* source/cache_data_store.sv */
`timescale 1ns/10ps

module cache_data_store (
    input  logic            clk,
    input  logic            set,
    input  cache_pkg::way_t way,
    input  logic [1:0]      offset,
    input  logic            write_word,
    input  mem_pkg::word_t  wdata,
    input  logic            fill,
    input  mem_pkg::line_t  fill_line,
    output mem_pkg::word_t  rdata,
    output mem_pkg::line_t  line_out
);

    mem_pkg::line_t data_q [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];

    mem_pkg::line_t merged;
    int             lsb;

    assign line_out = data_q[set][way];

    // word 0 sits at the top of the line
    always_comb begin
        lsb = (mem_pkg::WORDS_PER_LINE - 1 - int'(offset)) * mem_pkg::WORD_W;
    end

    assign rdata = line_out[lsb +: mem_pkg::WORD_W];

    always_comb begin
        merged                           = line_out;
        merged[lsb +: mem_pkg::WORD_W]   = wdata;
    end

    // fill replaces the whole line
    always_ff @(posedge clk) begin
        if (fill) begin
            data_q[set][way] <= fill_line;
        end else if (write_word) begin
            data_q[set][way] <= merged;
        end
    end

endmodule

/* source/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl (
    input  logic                          clk,
    input  logic                          reset_n,
    input  cache_pkg::cache_req_t         cpu_req,
    input  logic                          cpu_req_valid,
    output logic                          cpu_req_ready,
    output cache_pkg::cache_resp_t        cpu_resp,
    output logic                          cpu_resp_valid,
    input  logic                          cpu_resp_ready,
    output mem_pkg::mem_req_t             mem_req,
    output logic                          mem_req_valid,
    input  logic                          mem_req_ready,
    input  mem_pkg::mem_resp_t            mem_resp,
    input  logic                          mem_resp_valid,
    output logic [cache_pkg::COUNT_W-1:0] access_count,
    output logic [cache_pkg::COUNT_W-1:0] hit_count,
    output cache_pkg::cache_addr_u        lookup_addr,
    output logic                          touch,
    output cache_pkg::way_t               touch_way,
    output logic                          install,
    output cache_pkg::way_t               install_way,
    output logic                          set_dirty,
    input  logic                          hit,
    input  cache_pkg::way_t               hit_way,
    input  cache_pkg::way_t               victim_way,
    input  logic                          victim_dirty,
    input  mem_pkg::line_addr_t           victim_line_addr,
    output logic                          set,
    output cache_pkg::way_t               way,
    output logic [1:0]                    offset,
    output logic                          write_word,
    output mem_pkg::word_t                wdata,
    output logic                          fill,
    output mem_pkg::line_t                fill_line,
    input  mem_pkg::word_t                rdata,
    input  mem_pkg::line_t                line_out
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT,
        RESPOND
    } state_t;

    state_t                 state_q;
    state_t                 state_d;
    cache_pkg::cache_req_t  req_q;
    cache_pkg::cache_resp_t resp_q;
    logic                   retry_q;    // second lookup after a fill
    logic                   accept;
    logic                   lookup_hit;
    logic                   write_back;

    assign cpu_req_ready  = (state_q == IDLE);
    assign cpu_resp_valid = (state_q == RESPOND);
    assign cpu_resp       = resp_q;
    assign accept         = cpu_req_valid && cpu_req_ready;
    assign lookup_hit     = (state_q == LOOKUP) && hit;
    assign write_back     = (state_q == WRITEBACK);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (cpu_req_valid) state_d = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    state_d = RESPOND;
                end else if (victim_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = FILL_REQ;
                end
            end
            WRITEBACK: if (mem_req_ready) state_d = FILL_REQ;
            FILL_REQ:  if (mem_req_ready) state_d = FILL_WAIT;
            FILL_WAIT: if (mem_resp_valid) state_d = LOOKUP;    // retry hits now
            RESPOND:   if (cpu_resp_ready) state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q      <= IDLE;
            retry_q      <= 1'b0;
            access_count <= '0;
            hit_count    <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                access_count <= access_count + 1'b1;
                retry_q      <= 1'b0;
            end
            if (lookup_hit && !retry_q) begin
                hit_count <= hit_count + 1'b1;
            end
            if (state_q == LOOKUP && !hit) begin
                retry_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
        if (lookup_hit) begin
            resp_q.rdata <= req_q.write ? '0 : rdata;
            resp_q.hit   <= req_q.write || !retry_q;
        end
    end

    // tag store
    assign lookup_addr = req_q.addr;
    assign touch       = lookup_hit;
    assign touch_way   = hit_way;
    assign set_dirty   = req_q.write;
    assign install     = (state_q == FILL_WAIT) && mem_resp_valid;
    assign install_way = victim_way;

    // data store
    assign set        = req_q.addr.f.index;
    assign way        = (state_q == LOOKUP) ? hit_way : victim_way;
    assign offset     = req_q.addr.f.offset;
    assign write_word = lookup_hit && req_q.write;
    assign wdata      = req_q.wdata;
    assign fill       = install;
    assign fill_line  = mem_resp.rdata;

    // victim out first, then the missing line in
    assign mem_req_valid = write_back || (state_q == FILL_REQ);
    assign mem_req.write = write_back;
    assign mem_req.addr  = write_back ? victim_line_addr : req_q.addr.raw[mem_pkg::WORD_W-1:2];
    assign mem_req.wdata = write_back ? line_out : '0;

endmodule

/* source/main_memory.sv */
`timescale 1ns/10ps

module main_memory (
    input  logic               clk,
    input  logic               reset_n,
    input  mem_pkg::mem_req_t  mem_req,
    input  logic               mem_req_valid,
    output logic               mem_req_ready,
    output mem_pkg::mem_resp_t mem_resp,
    output logic               mem_resp_valid
);

    mem_pkg::line_t      mem_q [mem_pkg::MEM_LINES];
    mem_pkg::lat_cnt_t   busy_q;       // cycles left before ready
    logic                rd_pend_q;
    mem_pkg::line_addr_t rd_addr_q;
    logic                accept;

    initial begin
        for (int i = 0; i < mem_pkg::MEM_LINES; i++) begin
            mem_q[i] = '0;
        end
    end

    assign mem_req_ready = (busy_q == '0);
    assign accept        = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy_q    <= '0;
            rd_pend_q <= 1'b0;
        end else if (accept) begin
            busy_q    <= mem_pkg::lat_cnt_t'(mem_pkg::MEM_LATENCY);
            rd_pend_q <= !mem_req.write;
        end else if (busy_q != '0) begin
            busy_q <= busy_q - 1'b1;
            if (busy_q == mem_pkg::lat_cnt_t'(1)) begin
                rd_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !mem_req.write) begin
            rd_addr_q <= mem_req.addr;
        end
    end

    // write lands at accept
    always @(posedge clk) begin
        if (accept && mem_req.write) begin
            mem_q[mem_req.addr] <= mem_req.wdata;
        end
    end

    // last busy cycle carries the read data
    assign mem_resp_valid = rd_pend_q && (busy_q == mem_pkg::lat_cnt_t'(1));
    assign mem_resp.rdata = mem_q[rd_addr_q];

endmodule

/* source/cache_system.sv */
`timescale 1ns/10ps

module cache_system (
    input  logic                          clk,
    input  logic                          reset_n,
    input  cache_pkg::cache_req_t         cpu_req,
    input  logic                          cpu_req_valid,
    output logic                          cpu_req_ready,
    output cache_pkg::cache_resp_t        cpu_resp,
    output logic                          cpu_resp_valid,
    input  logic                          cpu_resp_ready,
    output logic [cache_pkg::COUNT_W-1:0] access_count,
    output logic [cache_pkg::COUNT_W-1:0] hit_count
);

    mem_pkg::mem_req_t      mem_req;
    logic                   mem_req_valid;
    logic                   mem_req_ready;
    mem_pkg::mem_resp_t     mem_resp;
    logic                   mem_resp_valid;

    cache_pkg::cache_addr_u lookup_addr;
    logic                   touch;
    cache_pkg::way_t        touch_way;
    logic                   install;
    cache_pkg::way_t        install_way;
    logic                   set_dirty;
    logic                   hit;
    cache_pkg::way_t        hit_way;
    cache_pkg::way_t        victim_way;
    logic                   victim_dirty;
    mem_pkg::line_addr_t    victim_line_addr;

    logic                   set;
    cache_pkg::way_t        way;
    logic [1:0]             offset;
    logic                   write_word;
    mem_pkg::word_t         wdata;
    logic                   fill;
    mem_pkg::line_t         fill_line;
    mem_pkg::word_t         rdata;
    mem_pkg::line_t         line_out;

    cache_ctrl i_ctrl (
        .clk              (clk),
        .reset_n          (reset_n),
        .cpu_req          (cpu_req),
        .cpu_req_valid    (cpu_req_valid),
        .cpu_req_ready    (cpu_req_ready),
        .cpu_resp         (cpu_resp),
        .cpu_resp_valid   (cpu_resp_valid),
        .cpu_resp_ready   (cpu_resp_ready),
        .mem_req          (mem_req),
        .mem_req_valid    (mem_req_valid),
        .mem_req_ready    (mem_req_ready),
        .mem_resp         (mem_resp),
        .mem_resp_valid   (mem_resp_valid),
        .access_count     (access_count),
        .hit_count        (hit_count),
        .lookup_addr      (lookup_addr),
        .touch            (touch),
        .touch_way        (touch_way),
        .install          (install),
        .install_way      (install_way),
        .set_dirty        (set_dirty),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .victim_dirty     (victim_dirty),
        .victim_line_addr (victim_line_addr),
        .set              (set),
        .way              (way),
        .offset           (offset),
        .write_word       (write_word),
        .wdata            (wdata),
        .fill             (fill),
        .fill_line        (fill_line),
        .rdata            (rdata),
        .line_out         (line_out)
    );

    cache_tag_store i_tags (
        .clk              (clk),
        .reset_n          (reset_n),
        .lookup_addr      (lookup_addr),
        .touch            (touch),
        .touch_way        (touch_way),
        .install          (install),
        .install_way      (install_way),
        .set_dirty        (set_dirty),
        .hit              (hit),
        .hit_way          (hit_way),
        .victim_way       (victim_way),
        .victim_dirty     (victim_dirty),
        .victim_line_addr (victim_line_addr)
    );

    cache_data_store i_data (
        .clk        (clk),
        .set        (set),
        .way        (way),
        .offset     (offset),
        .write_word (write_word),
        .wdata      (wdata),
        .fill       (fill),
        .fill_line  (fill_line),
        .rdata      (rdata),
        .line_out   (line_out)
    );

    main_memory i_mem (
        .clk            (clk),
        .reset_n        (reset_n),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_resp       (mem_resp),
        .mem_resp_valid (mem_resp_valid)
    );

endmodule

/* bench/cache_system_tb.sv */
`timescale 1ns/10ps

module cache_system_tb;

    localparam int          STIM_DEPTH = 6 * 64;    // six fields per line
    localparam int          WAIT_LIMIT = 50;
    localparam logic [15:0] OP_READ    = 16'h0;
    localparam logic [15:0] OP_WRITE   = 16'h1;
    localparam logic [15:0] OP_COUNT   = 16'h2;
    localparam logic [15:0] OP_END     = 16'hf;

    logic                          clk;
    logic                          reset_n;
    cache_pkg::cache_req_t         cpu_req;
    logic                          cpu_req_valid;
    logic                          cpu_req_ready;
    cache_pkg::cache_resp_t        cpu_resp;
    logic                          cpu_resp_valid;
    logic                          cpu_resp_ready;
    logic [cache_pkg::COUNT_W-1:0] access_count;
    logic [cache_pkg::COUNT_W-1:0] hit_count;

    logic [15:0] stim [STIM_DEPTH];
    int          tests_run;
    int          tests_failed;
    int          test_errors;
    logic        timed_out;

    cache_system i_dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .cpu_req        (cpu_req),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp       (cpu_resp),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_ready (cpu_resp_ready),
        .access_count   (access_count),
        .hit_count      (hit_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string sig, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
            test_errors++;
        end
    endtask

    // land 1 ns past the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_request(input logic write, input logic [15:0] addr,
                                input logic [15:0] data);
        int waited;
        waited            = 0;
        cpu_req.write     = write;
        cpu_req.addr.raw  = addr;
        cpu_req.wdata     = data;
        cpu_req_valid     = 1'b1;
        while (!cpu_req_ready && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (cpu_req_ready) begin
            next_cycle();    // transfer edge
        end else begin
            $display("cpu_req_ready stayed low for %0d cycles, request not taken", WAIT_LIMIT);
            test_errors++;
            timed_out = 1'b1;
        end
        cpu_req_valid = 1'b0;
    endtask

    // edges counted after the transfer edge
    task automatic wait_response(output int cycles);
        cycles = 0;
        while (!cpu_resp_valid && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!cpu_resp_valid) begin
            $display("no response within %0d cycles of the request", WAIT_LIMIT);
            test_errors++;
            timed_out = 1'b1;
        end
    endtask

    // response must sit still while the cpu side stalls
    task automatic hold_and_release(input int hold_cycles);
        cache_pkg::cache_resp_t held;
        held = cpu_resp;
        for (int i = 0; i < hold_cycles; i++) begin
            next_cycle();
            check_value("cpu_resp_valid", 16'(cpu_resp_valid), 16'h1);
            check_value("cpu_resp.rdata", cpu_resp.rdata, held.rdata);
            check_value("cpu_resp.hit", 16'(cpu_resp.hit), 16'(held.hit));
            check_value("cpu_req_ready", 16'(cpu_req_ready), 16'h0);
        end
        cpu_resp_ready = 1'b1;
        next_cycle();
        check_value("cpu_resp_valid", 16'(cpu_resp_valid), 16'h0);
        check_value("cpu_req_ready", 16'(cpu_req_ready), 16'h1);
    endtask

    task automatic report_test(input string what);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, what);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d error(s)", tests_run, what, test_errors);
        end
    endtask

    initial begin
        int          idx;
        int          line_no;
        int          cycles;
        logic [15:0] op;
        logic [15:0] addr;
        logic [15:0] wdata;
        logic [15:0] exp_data;
        logic [15:0] exp_hit;
        logic [15:0] hold;
        string       what;

        reset_n        = 1'b0;
        cpu_req        = '0;
        cpu_req_valid  = 1'b0;
        cpu_resp_ready = 1'b1;
        tests_run      = 0;
        tests_failed   = 0;
        test_errors    = 0;
        timed_out      = 1'b0;
        for (idx = 0; idx < STIM_DEPTH; idx++) begin
            stim[idx] = OP_END;    // unread entries end the run
        end
        $readmemh("bench/cache_stimulus.txt", stim);

        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;

        check_value("cpu_req_ready", 16'(cpu_req_ready), 16'h1);
        check_value("cpu_resp_valid", 16'(cpu_resp_valid), 16'h0);
        check_value("access_count", access_count, 16'h0);
        check_value("hit_count", hit_count, 16'h0);
        report_test("state after reset");

        idx     = 0;
        line_no = 0;
        while (idx < STIM_DEPTH && stim[idx] != OP_END && !timed_out) begin
            op          = stim[idx];
            addr        = stim[idx + 1];
            wdata       = stim[idx + 2];
            exp_data    = stim[idx + 3];
            exp_hit     = stim[idx + 4];
            hold        = stim[idx + 5];
            test_errors = 0;
            case (op)
                OP_READ, OP_WRITE: begin
                    what = (op == OP_WRITE) ? $sformatf("write %h <- %h", addr, wdata)
                                            : $sformatf("read %h", addr);
                    cpu_resp_ready = (hold == 16'h0);
                    send_request(op == OP_WRITE, addr, wdata);
                    if (!timed_out) begin
                        wait_response(cycles);
                    end
                    if (!timed_out) begin
                        check_value("cpu_resp.rdata", cpu_resp.rdata, exp_data);
                        check_value("cpu_resp.hit", 16'(cpu_resp.hit), exp_hit);
                        if (op == OP_READ && exp_hit == 16'h1) begin
                            check_value("hit response cycles", 16'(cycles), 16'h1);
                        end
                        hold_and_release(int'(hold));
                    end
                end
                OP_COUNT: begin
                    what = "counter check";
                    check_value("access_count", access_count, exp_data);
                    check_value("hit_count", hit_count, exp_hit);
                end
                default: begin
                    what = "bad stimulus line";
                    $display("unknown operation %h on stimulus line %0d", op, line_no);
                    test_errors++;
                end
            endcase
            report_test(what);
            idx += 6;
            line_no++;
        end

        assert (line_no > 0) else begin
            $display("no request lines were read from the stimulus file");
            tests_failed++;
        end

        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* cache_system.f */
source/mem_pkg.sv
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_ctrl.sv
source/main_memory.sv
source/cache_system.sv
bench/cache_system_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator and run from the project root, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cache_system_tb \
    -f cache_system.f -o cache_system_sim > build.log 2>&1 \
    && ./obj_dir/cache_system_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "test failed" sim.log && { echo "simulation reported a failure, see sim.log"; exit 1; }
echo "simulation clean, see sim.log"
exit 0

/* bench/cache_stimulus.txt */
// columns: op addr wdata exp_data exp_hit hold  (op 0 read, 1 write, 2 counters, f end)
// counter lines: exp_data is the expected access_count, exp_hit the expected hit_count
2 0000 0000 0000 0000 0
// cold line in set 1, then the rest of it hits
0 0004 0000 0000 0 0
0 0005 0000 0000 1 0
0 0006 0000 0000 1 0
0 0007 0000 0000 1 0
2 0000 0000 0004 0003 0
// word writes on a resident line
1 0004 1111 0000 1 0
1 0005 2222 0000 1 0
1 0006 3333 0000 1 0
1 0007 4444 0000 1 0
1 0005 a5a5 0000 1 0
0 0004 0000 1111 1 0
0 0005 0000 a5a5 1 0
0 0006 0000 3333 1 0
0 0007 0000 4444 1 0
2 0000 0000 000d 000c 0
// three tags into set 0, dirty evictions
1 0009 beef 0000 1 0
1 0012 cafe 0000 1 0
1 001b 1234 0000 1 0
0 0009 0000 beef 0 0
0 0008 0000 0000 1 0
0 0012 0000 cafe 0 0
0 001b 0000 1234 0 0
0 0013 0000 0000 1 0
2 0000 0000 0015 000e 0
// response back-pressure
0 0005 0000 a5a5 1 0
0 0006 0000 3333 1 5
0 0020 0000 0000 0 3
1 0021 7777 0000 1 2
0 0021 0000 7777 1 0
2 0000 0000 001a 0012 0
// write miss into set 1, then evictions there
1 000c 5555 0000 1 0
0 0014 0000 0000 0 0
0 0007 0000 4444 0 0
0 000c 0000 5555 0 0
2 0000 0000 001e 0012 0
f 0000 0000 0000 0 0
